// File: hdl/fp_pkg.sv
`default_nettype none

package fp_pkg;

  // single precision layout
  localparam int exp_bias = 127;  // ieee-754 exponent bias
  localparam int frac_w   = 23;   // stored fraction bits
  localparam int exp_w    = 8;    // biased exponent bits

  // datapath mantissa is two carry bits, hidden one, fraction and three guard bits
  localparam int ext_w = 29;

  // operation codes as held in the control register
  localparam logic op_add = 1'b0;  // add or subtract depending on operand signs
  localparam logic op_mul = 1'b1;  // multiply

  // word indexes taken from bus address bits 3 and 2
  localparam logic [1:0] reg_op_a   = 2'd0;  // operand a
  localparam logic [1:0] reg_op_b   = 2'd1;  // operand b
  localparam logic [1:0] reg_ctrl   = 2'd2;  // control on write and status on read
  localparam logic [1:0] reg_result = 2'd3;  // packed result word

  // bit positions inside the control and status word
  localparam int ctrl_busy_bit = 0;  // status read shows the engine running
  localparam int ctrl_done_bit = 1;  // status read shows a stored result
  localparam int ctrl_op_bit   = 0;  // control write selects the operation

  // field view of a float word
  typedef struct packed {
    logic              sign;  // sign bit
    logic [exp_w-1:0]  exp;   // biased exponent
    logic [frac_w-1:0] frac;  // fraction without the hidden one
  } fp_fields_t;

  // the bus sees raw words while the datapath works on the fields
  typedef union packed {
    logic [31:0] raw;  // word as written and read on the bus
    fp_fields_t  f;    // same word split into ieee fields
  } fp_word_u;

endpackage

`default_nettype wire

// File: hdl/operand_align.sv
`timescale 1ns/1ps
`default_nettype none

module operand_align (
  input  fp_pkg::fp_word_u                op_a,        // operand a as stored by the bus
  input  fp_pkg::fp_word_u                op_b,        // operand b as stored by the bus
  input  logic                            op,          // latched operation code
  output logic [fp_pkg::exp_w-1:0]        exp_big,     // larger of the two exponents
  output logic                            sign_big,    // sign of the operand with larger exponent
  output logic                            sign_small,  // sign of the other operand
  output logic [fp_pkg::ext_w-1:0]        mant_big,    // extended mantissa left in place
  output logic [fp_pkg::ext_w-1:0]        mant_small,  // extended mantissa shifted right
  output logic [fp_pkg::exp_w-1:0]        exp_sum      // biased exponent for a product
);

  logic                     a_big;      // operand a holds the larger or equal exponent
  logic [fp_pkg::exp_w-1:0] exp_diff;   // magnitude of the exponent difference
  logic [fp_pkg::exp_w-1:0] shift_amt;  // alignment distance actually applied
  logic [fp_pkg::ext_w-1:0] mant_a;     // operand a with hidden one and guard bits
  logic [fp_pkg::ext_w-1:0] mant_b;     // operand b with hidden one and guard bits
  logic [fp_pkg::ext_w-1:0] mant_low;   // mantissa that needs the shift

  always_comb begin
    mant_a = {2'b00, 1'b1, op_a.f.frac, 3'b000};  // carry bits zero and guard bits empty
    mant_b = {2'b00, 1'b1, op_b.f.frac, 3'b000};
    a_big  = (op_a.f.exp >= op_b.f.exp);  // ties leave a as the big operand
    exp_diff = a_big ? (op_a.f.exp - op_b.f.exp) : (op_b.f.exp - op_a.f.exp);
    // a product needs both mantissas unshifted so the distance drops to zero
    shift_amt = (op == fp_pkg::op_mul) ? '0 : exp_diff;
    exp_big    = a_big ? op_a.f.exp : op_b.f.exp;
    sign_big   = a_big ? op_a.f.sign : op_b.f.sign;
    sign_small = a_big ? op_b.f.sign : op_a.f.sign;
    mant_big   = a_big ? mant_a : mant_b;
    mant_low   = a_big ? mant_b : mant_a;
    // bits pushed past the guard bits are lost and a long shift leaves only zeros
    if (shift_amt >= 8'(fp_pkg::ext_w)) begin
      mant_small = '0;
    end else begin
      mant_small = mant_low >> shift_amt;
    end
    // modulo 256 arithmetic is exact while the product exponent stays in range
    exp_sum = op_a.f.exp + op_b.f.exp - 8'(fp_pkg::exp_bias);
  end

endmodule

`default_nettype wire

// File: hdl/mant_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mant_alu (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,       // one cycle pulse from the control fsm
  input  logic                     op,          // add or multiply
  input  logic [fp_pkg::ext_w-1:0] mant_big,    // unshifted extended mantissa
  input  logic [fp_pkg::ext_w-1:0] mant_small,  // aligned extended mantissa
  input  logic                     sign_big,
  input  logic                     sign_small,
  input  logic [fp_pkg::exp_w-1:0] exp_big,     // exponent for a sum
  input  logic [fp_pkg::exp_w-1:0] exp_sum,     // exponent for a product
  output logic                     done,        // one cycle pulse when mant_out is valid
  output logic [fp_pkg::ext_w-1:0] mant_out,    // sum or product before normalization
  output logic                     sign_out,
  output logic [fp_pkg::exp_w-1:0] exp_out
);

  logic                            mul_busy;   // shift-add loop in progress
  logic [4:0]                      step_cnt;   // shift-add steps already taken
  logic                            last_step;  // this edge takes the final step
  logic [fp_pkg::ext_w-1:0]        add_mag;    // magnitude of the signed sum
  logic                            add_sign;   // sign of the signed sum
  logic [fp_pkg::frac_w:0]         mcand_q;    // multiplicand held through the loop
  logic [fp_pkg::frac_w:0]         mcand_src;  // multiplicand used by the current step
  logic [2*fp_pkg::frac_w+1:0]     prod_q;     // partial product with multiplier in low half
  logic [2*fp_pkg::frac_w+1:0]     prod_src;   // product word entering the current step
  logic [2*fp_pkg::frac_w+1:0]     prod_step;  // product word after one step
  logic [fp_pkg::frac_w+1:0]       part_sum;   // upper half plus multiplicand with carry

  // sign magnitude add where the larger magnitude keeps its sign
  always_comb begin
    if (sign_big == sign_small) begin
      add_mag  = mant_big + mant_small;  // carry lands in bit 27
      add_sign = sign_big;
    end else if (mant_big >= mant_small) begin
      add_mag  = mant_big - mant_small;
      add_sign = sign_big;
    end else begin
      add_mag  = mant_small - mant_big;  // equal exponents with b larger end up here
      add_sign = sign_small;
    end
  end

  // the first step happens on the start edge so 24 steps end 24 cycles later
  always_comb begin
    mcand_src = start ? mant_big[fp_pkg::frac_w+3:3] : mcand_q;
    prod_src  = start ? {{(fp_pkg::frac_w+1){1'b0}}, mant_small[fp_pkg::frac_w+3:3]} : prod_q;
    part_sum  = {1'b0, prod_src[2*fp_pkg::frac_w+1:fp_pkg::frac_w+1]}
              + (prod_src[0] ? {1'b0, mcand_src} : '0);  // add when multiplier lsb is set
    prod_step = {part_sum, prod_src[fp_pkg::frac_w:1]};   // shift right by one
  end

  assign last_step = mul_busy && (step_cnt == 5'(fp_pkg::frac_w));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done     <= 1'b0;
      mul_busy <= 1'b0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;  // pulse only
      if (start) begin
        mul_busy <= (op == fp_pkg::op_mul);
        done     <= (op == fp_pkg::op_add);  // a sum is ready after one cycle
        step_cnt <= 5'd1;
      end else if (mul_busy) begin
        step_cnt <= step_cnt + 5'd1;
        if (last_step) begin
          mul_busy <= 1'b0;
          done     <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q <= mcand_src;
    end
    if (start || mul_busy) begin
      prod_q <= prod_step;
    end
    if (start) begin
      if (op == fp_pkg::op_add) begin
        mant_out <= add_mag;
        sign_out <= add_sign;
        exp_out  <= exp_big;  // the larger exponent carries over unchanged
      end else begin
        sign_out <= sign_big ^ sign_small;
        exp_out  <= exp_sum;
      end
    end else if (last_step) begin
      // product bit 46 becomes the hidden one at bit 26 and the low product bits drop
      mant_out <= {1'b0, prod_step[2*fp_pkg::frac_w+1:fp_pkg::frac_w-3]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/normalizer.sv
`timescale 1ns/1ps
`default_nettype none

module normalizer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,      // held high by the control fsm until done
  input  logic [fp_pkg::ext_w-1:0] mant_in,  // raw sum or product
  input  logic [fp_pkg::exp_w-1:0] exp_in,   // exponent before adjustment
  input  logic                     sign_in,
  output logic                     done,     // fraction is normalized or zero
  output fp_pkg::fp_word_u         result    // packed and truncated float word
);

  logic                     active;   // high from the second run cycle on
  logic [fp_pkg::ext_w-1:0] mant_q;   // working mantissa
  logic [fp_pkg::exp_w-1:0] exp_q;    // working exponent
  logic                     sign_q;   // sign held for packing
  logic                     is_zero;  // cancelled sum
  logic                     is_norm;  // leading one sits at bit 26

  assign is_zero = (mant_q == '0);
  assign is_norm = (mant_q[fp_pkg::ext_w-1:fp_pkg::frac_w+3] == 3'b001);
  assign done    = active && (is_zero || is_norm);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else begin
      active <= run;  // the first run cycle only loads
    end
  end

  // one bit position per cycle until the leading one reaches bit 26
  always_ff @(posedge clk) begin
    if (run && !active) begin
      mant_q <= mant_in;
      exp_q  <= exp_in;
      sign_q <= sign_in;
    end else if (run && !done) begin
      if (mant_q[fp_pkg::ext_w-1] || mant_q[fp_pkg::ext_w-2]) begin
        mant_q <= mant_q >> 1;     // carry out of the hidden bit and the lsb guard bit drops
        exp_q  <= exp_q + 8'd1;
      end else begin
        mant_q <= mant_q << 1;     // cancellation left the leading one too low
        exp_q  <= exp_q - 8'd1;
      end
    end
  end

  // guard bits are simply dropped which gives truncation
  always_comb begin
    result.raw = '0;  // a zero mantissa packs as +0
    if (!is_zero) begin
      result.f.sign = sign_q;
      result.f.exp  = exp_q;
      result.f.frac = mant_q[fp_pkg::frac_w+2:3];
    end
  end

endmodule

`default_nettype wire

// File: hdl/fp_control.sv
`timescale 1ns/1ps
`default_nettype none

module fp_control (
  input  logic clk,
  input  logic rst_n,
  input  logic start,      // accepted control write
  input  logic alu_done,   // mantissa alu finished
  input  logic norm_done,  // normalizer finished
  output logic alu_start,  // one cycle kick for the mantissa alu
  output logic norm_run,   // held while the normalizer loops
  output logic result_we,  // stores the packed result in the register block
  output logic busy,       // engine running
  output logic done        // sticky completion flag
);

  typedef enum logic [2:0] {
    st_idle,       // waiting for a start pulse
    st_compute,    // operands aligned and alu kicked off
    st_wait_alu,   // alu iterating
    st_normalize,  // normalizer loop running
    st_finish      // result written back
  } state_t;

  state_t state, state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:      if (start) state_nxt = st_compute;
      st_compute:   state_nxt = st_wait_alu;  // alignment is combinational so one cycle is enough
      st_wait_alu:  if (alu_done) state_nxt = st_normalize;
      st_normalize: if (norm_done) state_nxt = st_finish;
      st_finish:    state_nxt = st_idle;
      default:      state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (start) begin
        done <= 1'b0;  // a new operation hides the old result
      end else if (result_we) begin
        done <= 1'b1;
      end
    end
  end

  // outputs decoded straight from the state
  assign alu_start = (state == st_compute);
  assign norm_run  = (state == st_normalize);
  assign result_we = (state == st_finish);
  assign busy      = (state != st_idle);  // covers the result write cycle too

endmodule

`default_nettype wire

// File: hdl/fp_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fp_wb_regs (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [3:0]       wb_adr,     // byte address
  input  logic [31:0]      wb_dat_w,
  input  logic             busy,       // operand and control writes are locked out
  input  logic             done,
  input  logic             result_we,
  input  fp_pkg::fp_word_u result,
  output logic [31:0]      wb_dat_r,
  output logic             wb_ack,
  output fp_pkg::fp_word_u op_a,
  output fp_pkg::fp_word_u op_b,
  output logic             op,         // operation latched with the start write
  output logic             start       // one cycle start pulse
);

  logic        access;    // new cycle seen this clock
  logic        wr_ok;     // write that is allowed to land
  logic [1:0]  reg_sel;   // word index
  logic [31:0] status_w;  // status view of reg_ctrl
  logic [31:0] rd_word;   // read mux output
  logic [31:0] result_q;  // last stored result

  assign access  = wb_cyc && wb_stb && !wb_ack;  // ack low keeps one access per cycle
  assign reg_sel = wb_adr[3:2];
  // unaligned byte addresses and writes during an operation are dropped
  assign wr_ok   = access && wb_we && (wb_adr[1:0] == 2'b00) && !busy;

  always_comb begin
    status_w = '0;
    status_w[fp_pkg::ctrl_busy_bit] = busy;
    status_w[fp_pkg::ctrl_done_bit] = done;
    case (reg_sel)
      fp_pkg::reg_op_a:   rd_word = op_a.raw;
      fp_pkg::reg_op_b:   rd_word = op_b.raw;
      fp_pkg::reg_ctrl:   rd_word = status_w;
      fp_pkg::reg_result: rd_word = result_q;
      default:            rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      start    <= 1'b0;
      op       <= fp_pkg::op_add;
      op_a     <= '0;
      op_b     <= '0;
      result_q <= '0;
    end else begin
      wb_ack <= access;  // no wait states
      start  <= 1'b0;
      if (wr_ok) begin
        case (reg_sel)
          fp_pkg::reg_op_a: op_a.raw <= wb_dat_w;
          fp_pkg::reg_op_b: op_b.raw <= wb_dat_w;
          fp_pkg::reg_ctrl: begin
            op    <= wb_dat_w[fp_pkg::ctrl_op_bit];
            start <= 1'b1;  // rises together with ack
          end
          default: ;  // result word is read only
        endcase
      end
      if (result_we) begin
        result_q <= result.raw;
      end
    end
  end

  // read data is sampled on the accept edge and stays put while ack is high
  always_ff @(posedge clk) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fp_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_wb_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  fp_pkg::fp_word_u         op_a, op_b;          // operands held by the bus registers
  fp_pkg::fp_word_u         result;              // normalized and packed word
  logic                     op, start, busy, done;
  logic                     alu_start, alu_done;
  logic                     norm_run, norm_done, result_we;
  logic [fp_pkg::exp_w-1:0] exp_big, exp_sum;    // aligner exponents
  logic [fp_pkg::exp_w-1:0] alu_exp;             // exponent before normalization
  logic                     sign_big, sign_small, alu_sign;
  logic [fp_pkg::ext_w-1:0] mant_big, mant_small;
  logic [fp_pkg::ext_w-1:0] alu_mant;            // raw sum or product

  fp_wb_regs u_regs (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .busy(busy), .done(done),
    .result_we(result_we), .result(result), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .op_a(op_a), .op_b(op_b), .op(op), .start(start)
  );

  fp_control u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .alu_done(alu_done), .norm_done(norm_done),
    .alu_start(alu_start), .norm_run(norm_run), .result_we(result_we),
    .busy(busy), .done(done)
  );

  operand_align u_align (
    .op_a(op_a), .op_b(op_b), .op(op), .exp_big(exp_big), .sign_big(sign_big),
    .sign_small(sign_small), .mant_big(mant_big), .mant_small(mant_small),
    .exp_sum(exp_sum)
  );

  mant_alu u_alu (
    .clk(clk), .rst_n(rst_n), .start(alu_start), .op(op), .mant_big(mant_big),
    .mant_small(mant_small), .sign_big(sign_big), .sign_small(sign_small),
    .exp_big(exp_big), .exp_sum(exp_sum), .done(alu_done), .mant_out(alu_mant),
    .sign_out(alu_sign), .exp_out(alu_exp)
  );

  normalizer u_norm (
    .clk(clk), .rst_n(rst_n), .run(norm_run), .mant_in(alu_mant), .exp_in(alu_exp),
    .sign_in(alu_sign), .done(norm_done), .result(result)
  );

endmodule

`default_nettype wire

// File: bench/tb_fp_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_wb_top;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [8*24-1:0] t_name[$];    // test names as written in the trace
  logic            t_mul[$];     // set for a multiply, clear for an add
  logic [31:0]     t_a[$];       // operand a word
  logic [31:0]     t_b[$];       // operand b word
  logic [31:0]     t_exp[$];     // expected result word
  bit              trace_ready;  // watchdog budget depends on the number of tests

  fp_wb_top DUT (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input logic [8*24-1:0] name, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %0s %s expected %08h actual %08h", name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "wrong value");
    end
  endtask

  task automatic idle_gap();
    int unsigned n;
    n = $urandom_range(3, 0);  // zero to three idle cycles between bus cycles
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_ack();
    do begin
      @(posedge clk);
      #1;  // ack and read data have settled after the edge
    end while (!wb_ack);
  endtask

  task automatic wb_write(input logic [1:0] idx, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = {idx, 2'b00};  // word index sits on address bits 3 and 2
    wb_dat_w = data;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] idx, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = {idx, 2'b00};
    wait_ack();
    data   = wb_dat_r;  // valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic load_trace();
    int               fd;
    int               cnt;
    logic [8*128-1:0] line_buf;
    logic [8*24-1:0]  name;
    logic [8*4-1:0]   opname;
    logic [31:0]      a, b, r;
    fd = $fopen("bench/fp_trace.txt", "r");
    if (fd == 0)
      abort_run("cannot open bench/fp_trace.txt for reading");
    while ($fgets(line_buf, fd) != 0) begin
      cnt = $sscanf(line_buf, "%s %s %h %h %h", name, opname, a, b, r);
      if (cnt <= 0 || name == "#")
        continue;  // blank lines and column notes
      if (cnt != 5 || (opname != "add" && opname != "mul"))
        abort_run("malformed line in bench/fp_trace.txt");
      t_name.push_back(name);
      t_mul.push_back(opname == "mul");
      t_a.push_back(a);
      t_b.push_back(b);
      t_exp.push_back(r);
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int i);
    logic [31:0] rd;
    logic [31:0] op_word;    // control word that starts this test
    logic [31:0] busy_word;  // status while the engine runs
    logic [31:0] done_word;  // status once the result is stored
    int          polls;
    op_word   = (t_mul[i] ? 32'(fp_pkg::op_mul) : 32'(fp_pkg::op_add)) << fp_pkg::ctrl_op_bit;
    busy_word = 32'd1 << fp_pkg::ctrl_busy_bit;
    done_word = 32'd1 << fp_pkg::ctrl_done_bit;
    idle_gap();
    wb_write(fp_pkg::reg_op_a, t_a[i]);
    idle_gap();
    wb_write(fp_pkg::reg_op_b, t_b[i]);
    idle_gap();
    wb_read(fp_pkg::reg_op_a, rd);
    check_word(t_name[i], "operand a readback", t_a[i], rd);
    idle_gap();
    wb_read(fp_pkg::reg_op_b, rd);
    check_word(t_name[i], "operand b readback", t_b[i], rd);
    idle_gap();
    wb_write(fp_pkg::reg_ctrl, op_word);
    @(posedge clk);  // the fsm takes the start pulse one edge after the ack
    #1;
    wb_read(fp_pkg::reg_ctrl, rd);
    check_word(t_name[i], "status while running", busy_word, rd);
    if (t_mul[i]) begin
      // a multiply runs long enough for both writes to land while busy
      wb_write(fp_pkg::reg_op_a, ~t_a[i]);
      wb_write(fp_pkg::reg_ctrl, op_word ^ (32'd1 << fp_pkg::ctrl_op_bit));
    end
    polls = 0;
    do begin
      wb_read(fp_pkg::reg_ctrl, rd);
      polls++;
      assert (polls <= 200) else abort_run("operation never finished within 200 status reads");
    end while (!rd[fp_pkg::ctrl_done_bit]);
    check_word(t_name[i], "status after done", done_word, rd);
    idle_gap();
    wb_read(fp_pkg::reg_result, rd);
    check_word(t_name[i], "result", t_exp[i], rd);
    if (t_mul[i]) begin
      wb_read(fp_pkg::reg_op_a, rd);  // the write during busy must not have landed
      check_word(t_name[i], "operand a after busy write", t_a[i], rd);
    end
  endtask

  initial begin
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    rst_n       = 1'b0;
    trace_ready = 1'b0;
    void'($urandom(32'h4b29));  // single seed for the idle gaps
    load_trace();
    if (t_name.size() == 0)
      abort_run("bench/fp_trace.txt holds no tests");
    trace_ready = 1'b1;
    repeat (2) @(posedge clk);  // reset held for two cycles
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    repeat (2) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

  initial begin
    longint limit_ns;
    wait (trace_ready);
    limit_ns = longint'(t_name.size()) * 300 * 10 + 1000;  // 300 cycles per test plus 1 us
    #(limit_ns);
    abort_run($sformatf("timeout, the tests did not finish within %0d ns", limit_ns));
  end

endmodule

`default_nettype wire

// File: bench/fp_trace.txt
# columns: test name, operation (add or mul), operand a, operand b, expected result
# all words are ieee-754 single precision in hex
add_carry_shift_right add 3fc00000 40300000 40880000
add_equal_exp_carry   add 3f800000 3f800000 40000000
add_opp_sign_left     add 40400000 c0200000 3f000000
add_cancel_pos_big    add 40200000 c0200000 00000000
add_cancel_neg_big    add c0200000 40200000 00000000
add_both_negative     add bfc00000 c0300000 c0880000
add_left_two_steps    add 3f800000 bf400000 3e800000
add_neg_big_mag       add c0800000 3f800000 c0400000
add_shift_eight       add 42c80000 3e800000 42c88000
add_frac_lsb          add 3f800000 34000000 3f800001
add_guard_dropped     add 3f800000 33800000 3f800000
add_guard_borrow      add 3f800000 b3800000 3f7fffff
add_half_halves       add 3f000000 3f000000 3f800000
mul_sign_xor          mul bfc00000 40200000 c0700000
mul_sign_xor_swap     mul 40200000 bfc00000 c0700000
mul_overflow          mul 3fc00000 3fc00000 40100000
mul_overflow_exp      mul 40400000 40400000 41100000
mul_neg_neg           mul c0000000 c0000000 40800000
mul_exp_below_bias    mul 3f000000 40800000 40000000
mul_trunc_low         mul 3f800001 3f800001 3f800002
mul_trunc_overflow    mul 3fffffff 3fffffff 407ffffe
mul_scale             mul 42c80000 3e800000 41c80000
mul_one               mul 3f800000 c0700000 c0700000

// File: src.f
hdl/fp_pkg.sv
hdl/operand_align.sv
hdl/mant_alu.sv
hdl/normalizer.sv
hdl/fp_control.sv
hdl/fp_wb_regs.sv
hdl/fp_wb_top.sv
bench/tb_fp_wb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the bench with verilator and run it from the project root
verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_wb_top -f src.f -o sim_fp \
  && ./obj_dir/sim_fp \
  || { echo "run_sim.sh: build or simulation reported an error"; exit 1; }
